/* vlog.f */
+incdir+source
source/uart_pkg.sv
source/uart_fifo.sv
source/uart_baud_gen.sv
source/uart_tx.sv
source/uart_rx.sv
source/uart_top.sv
dv/uart_tb.sv

/* dv/uart_tb.sv */
/* Self-checking UART testbench with nco_i fixed at 0x8000, so one bit lasts 32 clocks.
   Stops at the first mismatch or timeout */
`timescale 1ns/1ps
`default_nettype none

`include "uart_params.svh"

module uart_tb;

  import uart_pkg::*;

  // A tick every second cycle and 16 ticks per bit
  localparam int unsigned BitCycles = 2 * `UART_OVERSAMPLE;
  localparam int unsigned WaitMax   = 40000;

  logic       clk_i;
  logic       rst_ni;
  uart_nco_t  nco_i;
  logic       tx_en_i;
  logic       rx_en_i;
  logic       parity_en_i;
  logic       parity_odd_i;
  logic       nf_en_i;
  logic       wvalid_i;
  uart_byte_t wdata_i;
  logic       tx_full_o;
  uart_lvl_t  tx_lvl_o;
  logic       tx_idle_o;
  logic       rready_i;
  uart_byte_t rdata_o;
  logic       rx_empty_o;
  uart_lvl_t  rx_lvl_o;
  logic       rx_idle_o;
  logic       rx_frame_err_o;
  logic       rx_parity_err_o;
  logic       rx_overflow_o;
  logic       rx_i;
  logic       tx_o;

  logic        loop_en;
  logic        drv_line;
  logic [31:0] rng_state;
  uart_byte_t  rxq[$];
  int          ovf_cnt  = 0;
  int          ferr_cnt = 0;
  int          perr_cnt = 0;

  uart_top dut_i (.*);

  // Loopback or a frame driven by the testbench
  assign rx_i = loop_en ? tx_o : drv_line;

  initial begin
    clk_i = 1'b0;
    forever #20 clk_i = ~clk_i;
  end

  // Count error and overflow strobes
  always @(posedge clk_i) begin
    if (rst_ni) begin
      if (rx_overflow_o) ovf_cnt <= ovf_cnt + 1;
      if (rx_frame_err_o) ferr_cnt <= ferr_cnt + 1;
      if (rx_parity_err_o) perr_cnt <= perr_cnt + 1;
    end
  end

  ////////////////////////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////////////////////////

  function automatic logic [31:0] xorshift32(logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  // Parity bit that makes the ones count even, or odd in odd mode
  function automatic logic parity_bit(uart_byte_t d, logic odd);
    logic ones_odd;
    ones_odd = (($countones(d) % 2) == 1);
    return odd ? !ones_odd : ones_odd;
  endfunction

  task automatic random_byte(output uart_byte_t b);
    rng_state = xorshift32(rng_state);
    b = rng_state[7:0];
  endtask

  task automatic abort_run();
    $display("*** TEST FAILED ***");
    $fatal(1, "Simulation stopped after an error");
  endtask

  task automatic check_byte(string what, uart_byte_t got, uart_byte_t exp);
    if (got !== exp) begin
      $display("Fail at %0t ns: %s is %h, expected %h", $time, what, got, exp);
      abort_run();
    end
  endtask

  task automatic check_lvl(string what, uart_lvl_t got, uart_lvl_t exp);
    if (got !== exp) begin
      $display("Fail at %0t ns: %s is %0d, expected %0d", $time, what, got, exp);
      abort_run();
    end
  endtask

  task automatic check_flag(string what, logic got, logic exp);
    if (got !== exp) begin
      $display("Fail at %0t ns: %s is %b, expected %b", $time, what, got, exp);
      abort_run();
    end
  endtask

  task automatic check_count(string what, int got, int exp);
    if (got != exp) begin
      $display("Fail at %0t ns: %s counted %0d, expected %0d", $time, what, got, exp);
      abort_run();
    end
  endtask

  task automatic step();
    @(posedge clk_i);
    #2;
  endtask

  task automatic wait_tx_idle();
    int n;
    n = 0;
    while (!tx_idle_o) begin
      step();
      n++;
      if (n > WaitMax) begin
        $display("Timed out at %0t ns waiting for the transmitter to go idle", $time);
        abort_run();
      end
    end
  endtask

  task automatic wait_tx_start();
    int n;
    n = 0;
    while (tx_o) begin
      step();
      n++;
      if (n > WaitMax) begin
        $display("Timed out at %0t ns waiting for a start bit on tx_o", $time);
        abort_run();
      end
    end
  endtask

  task automatic wait_rx_idle();
    int n;
    n = 0;
    while (!rx_idle_o) begin
      step();
      n++;
      if (n > WaitMax) begin
        $display("Timed out at %0t ns waiting for the receiver to go idle", $time);
        abort_run();
      end
    end
  endtask

  task automatic wait_rx_level(uart_lvl_t lvl);
    int n;
    n = 0;
    while (rx_lvl_o != lvl) begin
      step();
      n++;
      if (n > WaitMax) begin
        $display("Timed out at %0t ns waiting for %0d bytes in the RX FIFO", $time, lvl);
        abort_run();
      end
    end
  endtask

  task automatic push_byte(uart_byte_t b, uart_lvl_t exp_lvl);
    check_flag("tx_full_o before write", tx_full_o, 1'b0);
    wvalid_i = 1'b1;
    wdata_i  = b;
    step();
    wvalid_i = 1'b0;
    check_lvl("tx_lvl_o after write", tx_lvl_o, exp_lvl);
  endtask

  task automatic pop_byte();
    uart_byte_t exp;
    exp = rxq.pop_front();
    check_flag("rx_empty_o before read", rx_empty_o, 1'b0);
    check_byte("rdata_o", rdata_o, exp);
    rready_i = 1'b1;
    step();
    rready_i = 1'b0;
    check_lvl("rx_lvl_o after read", rx_lvl_o, uart_lvl_t'(rxq.size()));
  endtask

  task automatic drive_bit(logic v);
    drv_line = v;
    repeat (BitCycles) step();
  endtask

  // Frame on the line model with parity from the DUT setup
  task automatic send_frame(uart_byte_t d, logic bad_par, logic stop_bit);
    drive_bit(1'b0);
    for (int i = 0; i < `UART_CHAR_W; i++) begin
      drive_bit(d[i]);
    end
    if (parity_en_i) begin
      drive_bit(parity_bit(d, parity_odd_i) ^ bad_par);
    end
    drive_bit(stop_bit);
    drive_bit(1'b1);
  endtask

  ////////////////////////////////////////////////////////////
  // Test sequences
  ////////////////////////////////////////////////////////////

  task automatic loopback_run(int unsigned cnt, logic pen, logic podd);
    uart_byte_t b;
    int perr0;
    int ferr0;
    perr0        = perr_cnt;
    ferr0        = ferr_cnt;
    loop_en      = 1'b1;
    parity_en_i  = pen;
    parity_odd_i = podd;
    tx_en_i      = 1'b0;
    for (int i = 0; i < cnt; i++) begin
      random_byte(b);
      push_byte(b, uart_lvl_t'(i + 1));
      rxq.push_back(b);
    end
    tx_en_i = 1'b1;
    wait_tx_idle();
    wait_rx_level(uart_lvl_t'(cnt));
    while (rxq.size() > 0) begin
      pop_byte();
    end
    check_count("parity error pulses", perr_cnt, perr0);
    check_count("frame error pulses", ferr_cnt, ferr0);
  endtask

  // Sample tx_o in the middle of every bit
  task automatic tx_wave_run(logic pen, logic podd);
    uart_byte_t b;
    random_byte(b);
    loop_en      = 1'b1;
    parity_en_i  = pen;
    parity_odd_i = podd;
    tx_en_i      = 1'b0;
    push_byte(b, uart_lvl_t'(1));
    rxq.push_back(b);
    tx_en_i = 1'b1;
    wait_tx_start();
    repeat (BitCycles / 2) step();
    check_flag("tx_o start bit", tx_o, 1'b0);
    for (int i = 0; i < `UART_CHAR_W; i++) begin
      repeat (BitCycles) step();
      check_flag($sformatf("tx_o data bit %0d", i), tx_o, b[i]);
    end
    if (pen) begin
      repeat (BitCycles) step();
      check_flag("tx_o parity bit", tx_o, parity_bit(b, podd));
    end
    repeat (BitCycles) step();
    check_flag("tx_o stop bit", tx_o, 1'b1);
    wait_tx_idle();
    wait_rx_level(uart_lvl_t'(1));
    pop_byte();
  endtask

  task automatic error_frames_run();
    uart_byte_t b;
    int perr0;
    int ferr0;
    perr0        = perr_cnt;
    ferr0        = ferr_cnt;
    drv_line     = 1'b1;
    loop_en      = 1'b0;
    parity_en_i  = 1'b1;
    parity_odd_i = 1'b0;
    random_byte(b);
    send_frame(b, 1'b1, 1'b1);
    wait_rx_idle();
    check_count("parity error pulses", perr_cnt, perr0 + 1);
    check_count("frame error pulses", ferr_cnt, ferr0);
    check_flag("rx_empty_o after bad parity", rx_empty_o, 1'b1);
    random_byte(b);
    send_frame(b, 1'b0, 1'b0);
    wait_rx_idle();
    check_count("frame error pulses", ferr_cnt, ferr0 + 1);
    check_count("parity error pulses", perr_cnt, perr0 + 1);
    check_flag("rx_empty_o after bad stop bit", rx_empty_o, 1'b1);
  endtask

  task automatic overflow_run();
    uart_byte_t b;
    int ovf0;
    ovf0        = ovf_cnt;
    drv_line    = 1'b1;
    loop_en     = 1'b0;
    parity_en_i = 1'b0;
    for (int i = 0; i < `UART_RX_DEPTH + 1; i++) begin
      random_byte(b);
      send_frame(b, 1'b0, 1'b1);
      if (i < `UART_RX_DEPTH) begin
        rxq.push_back(b);
      end
    end
    wait_rx_idle();
    check_count("overflow pulses", ovf_cnt, ovf0 + 1);
    check_lvl("rx_lvl_o when full", rx_lvl_o, uart_lvl_t'(`UART_RX_DEPTH));
    while (rxq.size() > 0) begin
      pop_byte();
    end
  endtask

  task automatic glitch_run();
    int perr0;
    int ferr0;
    perr0    = perr_cnt;
    ferr0    = ferr_cnt;
    drv_line = 1'b1;
    loop_en  = 1'b0;
    nf_en_i  = 1'b1;
    repeat (4) step();
    drv_line = 1'b0;
    step();
    drv_line = 1'b1;
    repeat (2 * BitCycles) begin
      step();
      check_flag("rx_idle_o after glitch", rx_idle_o, 1'b1);
    end
    check_count("parity error pulses", perr_cnt, perr0);
    check_count("frame error pulses", ferr_cnt, ferr0);
    check_flag("rx_empty_o after glitch", rx_empty_o, 1'b1);
  endtask

  initial begin
    rst_ni       = 1'b0;
    nco_i        = 16'h8000;
    tx_en_i      = 1'b0;
    rx_en_i      = 1'b0;
    parity_en_i  = 1'b0;
    parity_odd_i = 1'b0;
    nf_en_i      = 1'b0;
    wvalid_i     = 1'b0;
    wdata_i      = '0;
    rready_i     = 1'b0;
    loop_en      = 1'b0;
    drv_line     = 1'b1;
    rng_state    = 32'h2195_47cb;
    repeat (3) @(posedge clk_i);
    #2;
    rst_ni = 1'b1;

    // State right after reset
    check_flag("tx_o after reset", tx_o, 1'b1);
    check_flag("tx_idle_o after reset", tx_idle_o, 1'b1);
    check_flag("rx_idle_o after reset", rx_idle_o, 1'b1);
    check_flag("rx_empty_o after reset", rx_empty_o, 1'b1);
    check_flag("tx_full_o after reset", tx_full_o, 1'b0);
    check_flag("rx_overflow_o after reset", rx_overflow_o, 1'b0);
    check_flag("rx_frame_err_o after reset", rx_frame_err_o, 1'b0);
    check_flag("rx_parity_err_o after reset", rx_parity_err_o, 1'b0);
    check_lvl("tx_lvl_o after reset", tx_lvl_o, '0);
    check_lvl("rx_lvl_o after reset", rx_lvl_o, '0);

    rx_en_i = 1'b1;
    loopback_run(20, 1'b0, 1'b0);
    loopback_run(12, 1'b1, 1'b0);
    loopback_run(12, 1'b1, 1'b1);
    tx_wave_run(1'b0, 1'b0);
    tx_wave_run(1'b1, 1'b0);
    tx_wave_run(1'b1, 1'b1);
    error_frames_run();
    overflow_run();
    glitch_run();

    $display("*** TEST PASSED ***");
    $finish;
  end

endmodule

`default_nettype wire

/* source/uart_top.sv */
/* UART core with strobe host ports and no back-pressure. A write to a full TX FIFO
   and a byte received into a full RX FIFO are both lost */
`timescale 1ns/1ps
`default_nettype none

`include "uart_params.svh"

module uart_top (
  input  wire                  clk_i,
  input  wire                  rst_ni,
  input  wire uart_pkg::uart_nco_t nco_i,
  input  wire                  tx_en_i,
  input  wire                  rx_en_i,
  input  wire                  parity_en_i,
  input  wire                  parity_odd_i,
  input  wire                  nf_en_i,
  input  wire                  wvalid_i,
  input  wire uart_pkg::uart_byte_t wdata_i,
  output logic                 tx_full_o,
  output uart_pkg::uart_lvl_t  tx_lvl_o,
  output logic                 tx_idle_o,
  input  wire                  rready_i,
  output uart_pkg::uart_byte_t rdata_o,
  output logic                 rx_empty_o,
  output uart_pkg::uart_lvl_t  rx_lvl_o,
  output logic                 rx_idle_o,
  output logic                 rx_frame_err_o,
  output logic                 rx_parity_err_o,
  output logic                 rx_overflow_o,
  input  wire                  rx_i,
  output logic                 tx_o
);

  import uart_pkg::*;

  logic       tick_x16;
  logic       tx_fifo_wready;
  logic       tx_fifo_rvalid;
  logic       tx_fifo_pop;
  uart_byte_t tx_fifo_data;
  logic       tx_ser_idle;
  logic       rx_valid;
  uart_byte_t rx_data;
  logic       rx_fifo_wvalid;
  logic       rx_fifo_wready;
  logic       rx_fifo_rvalid;

  uart_baud_gen u_baud_gen (
    .clk_i,
    .rst_ni,
    .en_i       (tx_en_i | rx_en_i),
    .nco_i,
    .tick_x16_o (tick_x16)
  );

  ////////////////////////////////////////////////////////////
  // Transmit path
  ////////////////////////////////////////////////////////////

  uart_fifo #(
    .Depth (`UART_TX_DEPTH)
  ) u_tx_fifo (
    .clk_i,
    .rst_ni,
    .wvalid_i (wvalid_i),
    .wdata_i  (wdata_i),
    .wready_o (tx_fifo_wready),
    .rvalid_o (tx_fifo_rvalid),
    .rready_i (tx_fifo_pop),
    .rdata_o  (tx_fifo_data),
    .lvl_o    (tx_lvl_o)
  );

  // Start the next frame as soon as the serializer is free
  assign tx_fifo_pop = tx_ser_idle & tx_fifo_rvalid & tx_en_i;

  uart_tx u_tx (
    .clk_i,
    .rst_ni,
    .en_i         (tx_en_i),
    .tick_x16_i   (tick_x16),
    .parity_en_i,
    .parity_odd_i,
    .wr_i         (tx_fifo_pop),
    .wr_data_i    (tx_fifo_data),
    .idle_o       (tx_ser_idle),
    .tx_o
  );

  assign tx_full_o = ~tx_fifo_wready;
  assign tx_idle_o = tx_ser_idle & ~tx_fifo_rvalid;

  ////////////////////////////////////////////////////////////
  // Receive path
  ////////////////////////////////////////////////////////////

  uart_rx u_rx (
    .clk_i,
    .rst_ni,
    .en_i         (rx_en_i),
    .tick_x16_i   (tick_x16),
    .parity_en_i,
    .parity_odd_i,
    .nf_en_i,
    .rx_i,
    .valid_o      (rx_valid),
    .data_o       (rx_data),
    .frame_err_o  (rx_frame_err_o),
    .parity_err_o (rx_parity_err_o),
    .idle_o       (rx_idle_o)
  );

  // Bad frames never reach the FIFO
  assign rx_fifo_wvalid = rx_valid & ~rx_frame_err_o & ~rx_parity_err_o;
  assign rx_overflow_o  = rx_fifo_wvalid & ~rx_fifo_wready;

  uart_fifo #(
    .Depth (`UART_RX_DEPTH)
  ) u_rx_fifo (
    .clk_i,
    .rst_ni,
    .wvalid_i (rx_fifo_wvalid),
    .wdata_i  (rx_data),
    .wready_o (rx_fifo_wready),
    .rvalid_o (rx_fifo_rvalid),
    .rready_i (rready_i),
    .rdata_o  (rdata_o),
    .lvl_o    (rx_lvl_o)
  );

  assign rx_empty_o = ~rx_fifo_rvalid;

endmodule

`default_nettype wire

/* source/uart_rx.sv */
/* Frame receiver sampling mid-bit on the 16x tick. Error flags are valid only
   with valid_o; dropping en_i returns the receiver to IDLE */
`timescale 1ns/1ps
`default_nettype none

`include "uart_params.svh"

module uart_rx (
  input  wire                  clk_i,
  input  wire                  rst_ni,
  input  wire                  en_i,
  input  wire                  tick_x16_i,
  input  wire                  parity_en_i,
  input  wire                  parity_odd_i,
  input  wire                  nf_en_i,
  input  wire                  rx_i,
  output logic                 valid_o,
  output uart_pkg::uart_byte_t data_o,
  output logic                 frame_err_o,
  output logic                 parity_err_o,
  output logic                 idle_o
);

  import uart_pkg::*;

  localparam int unsigned TickW = $clog2(`UART_OVERSAMPLE);
  localparam int unsigned BitW  = $clog2(`UART_CHAR_W);

  logic           sync_meta_q;
  logic           sync_q;
  logic           samp_q1;
  logic           samp_q2;
  logic           rx_maj;
  logic           rx_in;
  logic           rx_in_q;
  logic           fall;
  logic           tick;
  logic           half_pt;
  logic           full_pt;
  uart_rx_state_e state_q;
  logic [TickW-1:0] tick_cnt_q;
  logic [BitW-1:0]  bit_idx_q;
  uart_byte_t     data_q;
  logic           par_err_q;

  //////////////////////////////////////////////////////////////
  // Line conditioning
  //////////////////////////////////////////////////////////////

  // Two-flop synchronizer plus two more samples for the filter
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      sync_meta_q <= 1'b1;
      sync_q      <= 1'b1;
      samp_q1     <= 1'b1;
      samp_q2     <= 1'b1;
      rx_in_q     <= 1'b1;
    end else begin
      sync_meta_q <= rx_i;
      sync_q      <= sync_meta_q;
      samp_q1     <= sync_q;
      samp_q2     <= samp_q1;
      rx_in_q     <= rx_in;
    end
  end

  // Majority of three rejects single-cycle spikes
  assign rx_maj = (sync_q & samp_q1) | (sync_q & samp_q2) | (samp_q1 & samp_q2);
  assign rx_in  = nf_en_i ? rx_maj : sync_q;
  assign fall   = rx_in_q & ~rx_in;

  assign tick    = en_i & tick_x16_i;
  assign half_pt = (tick_cnt_q == TickW'(`UART_OVERSAMPLE / 2 - 1));
  assign full_pt = (tick_cnt_q == TickW'(`UART_OVERSAMPLE - 1));

  //////////////////////////////////////////////////////////////
  // Frame FSM
  //////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q      <= IDLE;
      tick_cnt_q   <= '0;
      bit_idx_q    <= '0;
      par_err_q    <= 1'b0;
      valid_o      <= 1'b0;
      frame_err_o  <= 1'b0;
      parity_err_o <= 1'b0;
    end else begin
      valid_o      <= 1'b0;
      frame_err_o  <= 1'b0;
      parity_err_o <= 1'b0;
      if (!en_i) begin
        state_q <= IDLE;
      end else begin
        unique case (state_q)
          IDLE: begin
            if (fall) begin
              state_q    <= START;
              tick_cnt_q <= '0;
            end
          end
          START: begin
            if (tick) begin
              tick_cnt_q <= half_pt ? '0 : tick_cnt_q + 1'b1;
              // A high in the middle of the start bit was noise
              if (half_pt) begin
                state_q   <= rx_in ? IDLE : DATA;
                bit_idx_q <= '0;
                par_err_q <= 1'b0;
              end
            end
          end
          DATA: begin
            if (tick) begin
              tick_cnt_q <= full_pt ? '0 : tick_cnt_q + 1'b1;
              if (full_pt) begin
                bit_idx_q <= bit_idx_q + 1'b1;
                if (bit_idx_q == BitW'(`UART_CHAR_W - 1)) begin
                  state_q <= parity_en_i ? PARITY : STOP;
                end
              end
            end
          end
          PARITY: begin
            if (tick) begin
              tick_cnt_q <= full_pt ? '0 : tick_cnt_q + 1'b1;
              if (full_pt) begin
                par_err_q <= rx_in ^ (^data_q) ^ parity_odd_i;
                state_q   <= STOP;
              end
            end
          end
          STOP: begin
            if (tick) begin
              tick_cnt_q <= full_pt ? '0 : tick_cnt_q + 1'b1;
              if (full_pt) begin
                valid_o      <= 1'b1;
                frame_err_o  <= ~rx_in;
                parity_err_o <= par_err_q & parity_en_i;
                state_q      <= IDLE;
              end
            end
          end
          default: state_q <= IDLE;
        endcase
      end
    end
  end

  // Data bits arrive LSB first
  always_ff @(posedge clk_i) begin
    if (state_q == DATA && tick && full_pt) begin
      data_q <= {rx_in, data_q[`UART_CHAR_W-1:1]};
    end
  end

  assign data_o = data_q;
  assign idle_o = (state_q == IDLE);

endmodule

`default_nettype wire

/* source/uart_tx.sv */
/* Frame serializer for start, data LSB first, optional parity and one stop bit.
   wr_i is only taken while idle; a frame pauses while en_i is low */
`timescale 1ns/1ps
`default_nettype none

`include "uart_params.svh"

module uart_tx (
  input  wire                  clk_i,
  input  wire                  rst_ni,
  input  wire                  en_i,
  input  wire                  tick_x16_i,
  input  wire                  parity_en_i,
  input  wire                  parity_odd_i,
  input  wire                  wr_i,
  input  wire uart_pkg::uart_byte_t wr_data_i,
  output logic                 idle_o,
  output logic                 tx_o
);

  localparam int unsigned TickW  = $clog2(`UART_OVERSAMPLE);
  localparam int unsigned FrameW = `UART_CHAR_W + 3;
  localparam int unsigned CntW   = $clog2(FrameW + 1);

  logic [FrameW-1:0] sreg_q;
  logic [CntW-1:0]   bits_q;
  logic [TickW-1:0]  tick_cnt_q;
  logic              busy;
  logic              load;
  logic              bit_end;
  logic              parity;
  logic              ser;

  // Even parity makes the ones count even and odd mode inverts it
  assign parity = (^wr_data_i) ^ parity_odd_i;

  assign busy    = (bits_q != '0);
  assign load    = wr_i & ~busy;
  assign bit_end = en_i & tick_x16_i & (tick_cnt_q == TickW'(`UART_OVERSAMPLE - 1));
  assign ser     = busy ? sreg_q[0] : 1'b1;
  assign idle_o  = ~busy;

  //////////////////////////////////////////////////////////////
  // Bit timing
  //////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      bits_q     <= '0;
      tick_cnt_q <= '0;
    end else if (load) begin
      // Without parity the stop bit goes out from the parity slot
      bits_q     <= parity_en_i ? CntW'(FrameW) : CntW'(FrameW - 1);
      tick_cnt_q <= '0;
    end else if (busy && en_i && tick_x16_i) begin
      tick_cnt_q <= bit_end ? '0 : tick_cnt_q + 1'b1;
      if (bit_end) begin
        bits_q <= bits_q - 1'b1;
      end
    end
  end

  // Frame shift register with the LSB out first
  always_ff @(posedge clk_i) begin
    if (load) begin
      sreg_q <= {1'b1, (parity_en_i ? parity : 1'b1), wr_data_i, 1'b0};
    end else if (busy && bit_end) begin
      sreg_q <= {1'b1, sreg_q[FrameW-1:1]};
    end
  end

  // Line flop that idles high
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      tx_o <= 1'b1;
    end else begin
      tx_o <= ser;
    end
  end

endmodule

`default_nettype wire

/* source/uart_baud_gen.sv */
/* Fractional 16x baud tick at f_clk * nco_i / 2^UART_NCO_W.
   The tick is the registered carry, so it lags the add by one cycle */
`timescale 1ns/1ps
`default_nettype none

`include "uart_params.svh"

module uart_baud_gen (
  input  wire                  clk_i,
  input  wire                  rst_ni,
  input  wire                  en_i,
  input  wire uart_pkg::uart_nco_t nco_i,
  output logic                 tick_x16_o
);

  // Top bit holds the carry of the last add
  logic [`UART_NCO_W:0] acc_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      acc_q <= '0;
    end else if (en_i) begin
      acc_q <= {1'b0, acc_q[`UART_NCO_W-1:0]} + {1'b0, nco_i};
    end else begin
      // Hold the phase but drop a pending tick
      acc_q[`UART_NCO_W] <= 1'b0;
    end
  end

  assign tick_x16_o = acc_q[`UART_NCO_W];

endmodule

`default_nettype wire

/* source/uart_fifo.sv */
/* Single-clock byte FIFO, head shown combinationally while rvalid_o is high.
   A push while full is dropped; Depth must not exceed what uart_lvl_t can count */
`timescale 1ns/1ps
`default_nettype none

module uart_fifo #(
  parameter int unsigned Depth = 32
) (
  input  wire                  clk_i,
  input  wire                  rst_ni,
  input  wire                  wvalid_i,
  input  wire uart_pkg::uart_byte_t wdata_i,
  output logic                 wready_o,
  output logic                 rvalid_o,
  input  wire                  rready_i,
  output uart_pkg::uart_byte_t rdata_o,
  output uart_pkg::uart_lvl_t  lvl_o
);

  import uart_pkg::*;

  localparam int unsigned PtrW = (Depth > 1) ? $clog2(Depth) : 1;

  uart_byte_t      mem [Depth];
  logic [PtrW-1:0] wptr_q;
  logic [PtrW-1:0] rptr_q;
  uart_lvl_t       lvl_q;
  logic            push;
  logic            pop;

  assign wready_o = (lvl_q != uart_lvl_t'(Depth));
  assign rvalid_o = (lvl_q != '0);
  assign push     = wvalid_i & wready_o;
  assign pop      = rready_i & rvalid_o;

  assign rdata_o = mem[rptr_q];
  assign lvl_o   = lvl_q;

  //////////////////////////////////////////////////////////////
  // Pointers and level
  //////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wptr_q <= '0;
      rptr_q <= '0;
      lvl_q  <= '0;
    end else begin
      if (push) begin
        wptr_q <= (wptr_q == PtrW'(Depth - 1)) ? '0 : wptr_q + 1'b1;
      end
      if (pop) begin
        rptr_q <= (rptr_q == PtrW'(Depth - 1)) ? '0 : rptr_q + 1'b1;
      end
      // Push and pop together leave the level unchanged
      if (push && !pop) begin
        lvl_q <= lvl_q + 1'b1;
      end else if (pop && !push) begin
        lvl_q <= lvl_q - 1'b1;
      end
    end
  end

  // Storage
  always_ff @(posedge clk_i) begin
    if (push) begin
      mem[wptr_q] <= wdata_i;
    end
  end

endmodule

`default_nettype wire

/* source/uart_pkg.sv */
/* Types shared by the UART blocks and the testbench.
   The level type holds the larger FIFO depth inclusive */
`default_nettype none

`include "uart_params.svh"

package uart_pkg;

  // One character on the line
  typedef logic [`UART_CHAR_W-1:0] uart_byte_t;

  // Baud increment added per enabled cycle
  typedef logic [`UART_NCO_W-1:0] uart_nco_t;

  // FIFO fill level, 0 up to full
  typedef logic [$clog2(((`UART_TX_DEPTH > `UART_RX_DEPTH) ?
                         `UART_TX_DEPTH : `UART_RX_DEPTH) + 1)-1:0] uart_lvl_t;

  // Receiver frame position
  typedef enum logic [2:0] {
    IDLE,
    START,
    DATA,
    PARITY,
    STOP
  } uart_rx_state_e;

endpackage

`default_nettype wire

/* source/uart_params.svh */
/* Build-time sizes for the UART. Both FIFO depths must fit the level type in uart_pkg,
   and the oversampling rate must be a power of two */
`ifndef UART_PARAMS_SVH
`define UART_PARAMS_SVH

// Width of the fractional baud increment
`define UART_NCO_W 16

// FIFO depths in characters
`define UART_TX_DEPTH 32
`define UART_RX_DEPTH 32

// Baud ticks per bit on the line
`define UART_OVERSAMPLE 16

// Data bits per character, sent LSB first
`define UART_CHAR_W 8

`endif
